//--- Makefile
VERILATOR  ?= verilator
TOP        := line_tracker_tb
FILELIST   := line_tracker.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TESTBENCH PASSED
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/line_tracker_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_tracker_defines.svh"

// reference model of the tracker
// compares at every falling edge, when all DUT signals are settled
module line_tracker_checker (
	input  logic clock_i,
	input  logic resetn_i,
	input  line_tracker_pkg::tracker_ctrl_t ctrl_i,
	input  logic request_i,
	input  logic en_i,
	input  line_tracker_pkg::expiry_set_t expiry_i,
	input  logic stall_i,
	input  line_tracker_pkg::buf_count_t count_i,
	input  line_tracker_pkg::expiry_set_t rd_expiry_i,
	input  line_tracker_pkg::trace_t rd_trace_i,
	output int errors_o,
	output int read_checks_o
);

	// expected result of one host read
	typedef struct packed {
		logic valid;
		line_tracker_pkg::buf_addr_t addr;
		line_tracker_pkg::expiry_set_t expiry;
		line_tracker_pkg::trace_t trace;
	} readout_t;

	// ------------------------------
	// model state
	// ------------------------------
	logic model_live = 1'b0;
	int model_period;
	line_tracker_pkg::trace_t model_trace;
	int model_count;
	logic model_stall;
	// previous edges with stall high, back to back
	int stall_hold;

	// model buffer, filled at the sample decision
	line_tracker_pkg::expiry_set_t buf_expiry [`LT_BUF_DEPTH];
	line_tracker_pkg::trace_t buf_trace [`LT_BUF_DEPTH];
	logic buf_valid [`LT_BUF_DEPTH];

	// reads in flight: arbiter stage, then RAM stage
	line_tracker_pkg::buf_addr_t rd_prev;
	readout_t rd_port;
	readout_t rd_ram;

	int error_count = 0;
	int read_count = 0;

	assign errors_o = error_count;
	assign read_checks_o = read_count;

	task automatic compare_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic reset_model();
		model_period = `LT_SAMPLE_PERIOD;
		model_trace = '0;
		model_count = 0;
		model_stall = 1'b0;
		stall_hold = 0;
		rd_prev = ctrl_i.rd_addr;
		rd_port = '0;
		rd_ram = '0;
		// RAM contents are unknown after reset
		for (int i = 0; i < `LT_BUF_DEPTH; i++) begin
			buf_valid[i] = 1'b0;
		end
	endtask

	// advance the model by the inputs of the coming rising edge
	task automatic step_model();
		logic counted;
		logic host;
		// host owns the port when tracking is off or stall is old enough
		host = !ctrl_i.track_en || (model_stall && stall_hold >= 1);
		rd_ram = rd_port;
		rd_port.valid = host && (ctrl_i.rd_addr == rd_prev) && buf_valid[ctrl_i.rd_addr];
		rd_port.addr = ctrl_i.rd_addr;
		rd_port.expiry = buf_expiry[ctrl_i.rd_addr];
		rd_port.trace = buf_trace[ctrl_i.rd_addr];
		rd_prev = ctrl_i.rd_addr;
		stall_hold = model_stall ? stall_hold + 1 : 0;

		counted = ctrl_i.track_en && !model_stall && en_i && request_i;
		// clear empties the buffer, trace and period go on
		if (ctrl_i.clear) begin
			model_count = 0;
			model_stall = 1'b0;
		end
		if (counted) begin
			model_period = model_period - 1;
			if (model_period == 0) begin
				model_period = `LT_SAMPLE_PERIOD;
				// record holds the requests counted before this one
				buf_expiry[model_count] = expiry_i;
				buf_trace[model_count] = model_trace;
				buf_valid[model_count] = 1'b1;
				model_count = model_count + 1;
				model_stall = (model_count == `LT_BUF_DEPTH);
			end
			model_trace = model_trace + 1;
		end
	endtask

	always @(negedge clock_i) begin
		if (model_live) begin
			compare_value("stall_o", 64'(model_stall), 64'(stall_i));
			compare_value("count_o", 64'(model_count), 64'(count_i));
		end
		if (rd_ram.valid) begin
			read_count++;
			compare_value($sformatf("expiry_o[%0d]", rd_ram.addr), 64'(rd_ram.expiry),
				64'(rd_expiry_i));
			compare_value($sformatf("trace_o[%0d]", rd_ram.addr), 64'(rd_ram.trace),
				64'(rd_trace_i));
		end
		if (!resetn_i) begin
			reset_model();
			model_live = 1'b1;
		end else if (model_live) begin
			step_model();
		end
	end

endmodule

`default_nettype wire

//--- bench/line_tracker_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_tracker_defines.svh"

module line_tracker_tb;

	localparam int FILL_TIMEOUT = 1000;
	localparam int REFILL_TIMEOUT = 200;
	// samples taken after the clear
	localparam int REFILL_SAMPLES = 6;

	logic clock;
	logic resetn;
	line_tracker_pkg::tracker_ctrl_t ctrl;
	logic request;
	logic en;
	line_tracker_pkg::expiry_set_t expiry;
	logic stall;
	line_tracker_pkg::buf_count_t count;
	line_tracker_pkg::expiry_set_t rd_expiry;
	line_tracker_pkg::trace_t rd_trace;

	logic [31:0] lfsr_state;
	int timeouts;
	int value_errors;
	int read_checks;

	line_tracker_top DUT (
		.clock_i  (clock),
		.resetn_i (resetn),
		.ctrl_i   (ctrl),
		.request_i(request),
		.en_i     (en),
		.expiry_i (expiry),
		.stall_o  (stall),
		.count_o  (count),
		.expiry_o (rd_expiry),
		.trace_o  (rd_trace)
	);

	line_tracker_checker u_checker (
		.clock_i      (clock),
		.resetn_i     (resetn),
		.ctrl_i       (ctrl),
		.request_i    (request),
		.en_i         (en),
		.expiry_i     (expiry),
		.stall_i      (stall),
		.count_i      (count),
		.rd_expiry_i  (rd_expiry),
		.rd_trace_i   (rd_trace),
		.errors_o     (value_errors),
		.read_checks_o(read_checks)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// ------------------------------
	// random source
	// ------------------------------

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// one LFSR step per returned bit
	function automatic logic [63:0] random_bits(input int width);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[62:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// one clock of stimulus, driven just after the rising edge
	task automatic drive_cycle(input logic track, input logic clr,
			input line_tracker_pkg::buf_addr_t addr, input logic active);
		logic [63:0] bits;
		@(posedge clock);
		#1;
		ctrl = '{track_en: track, clear: clr, rd_addr: addr};
		if (active) begin
			// about 70 % requests, en_i high 7 times out of 8
			request = (random_bits(7) < 64'd90);
			en = (random_bits(3) != 64'd0);
			bits = random_bits(48);
			expiry = bits[47:0];
		end else begin
			request = 1'b0;
			en = 1'b1;
		end
	endtask

	// every address held two cycles, random requests meanwhile
	task automatic read_buffer(input logic track);
		for (int a = 0; a < `LT_BUF_DEPTH; a++) begin
			drive_cycle(track, 1'b0, line_tracker_pkg::buf_addr_t'(a), 1'b1);
			drive_cycle(track, 1'b0, line_tracker_pkg::buf_addr_t'(a), 1'b1);
		end
	endtask

	task automatic fill_until_stall();
		int cycles;
		cycles = 0;
		while (stall !== 1'b1 && cycles < FILL_TIMEOUT) begin
			drive_cycle(1'b1, 1'b0, '0, 1'b1);
			cycles++;
		end
		if (stall !== 1'b1) begin
			timeouts++;
			$display("timeout: stall_o did not rise within %0d cycles", FILL_TIMEOUT);
		end
	endtask

	task automatic refill_to_count();
		int cycles;
		cycles = 0;
		while (count < REFILL_SAMPLES && cycles < REFILL_TIMEOUT) begin
			drive_cycle(1'b1, 1'b0, '0, 1'b1);
			cycles++;
		end
		if (count < REFILL_SAMPLES) begin
			timeouts++;
			$display("timeout: buffer took no %0d samples after the clear", REFILL_SAMPLES);
		end
	endtask

	initial begin
		lfsr_state = 32'd89727;
		timeouts = 0;
		resetn = 1'b0;
		ctrl = '0;
		request = 1'b0;
		en = 1'b0;
		expiry = '0;
		repeat (3) @(posedge clock);
		#1;
		resetn = 1'b1;

		// random tracking, then fill up and keep requesting while stalled
		repeat (40) drive_cycle(1'b1, 1'b0, '0, 1'b1);
		fill_until_stall();
		repeat (10) drive_cycle(1'b1, 1'b0, '0, 1'b1);

		// readout through the stall, then clear
		read_buffer(1'b1);
		repeat (3) drive_cycle(1'b1, 1'b0, '0, 1'b0);
		drive_cycle(1'b1, 1'b1, '0, 1'b0);
		// clear takes effect on the following edge, count is zero after it
		drive_cycle(1'b1, 1'b0, '0, 1'b0);

		// partial refill, quiet so the last write lands before tracking stops
		refill_to_count();
		repeat (4) drive_cycle(1'b1, 1'b0, '0, 1'b0);
		read_buffer(1'b0);
		repeat (3) drive_cycle(1'b0, 1'b0, '0, 1'b0);

		if (read_checks < 2 * `LT_BUF_DEPTH) begin
			$display("fewer buffer readouts were checked than expected");
		end
		$display("counts: %0d value errors, %0d timeouts, %0d readouts checked",
			value_errors, timeouts, read_checks);
		if (value_errors == 0 && timeouts == 0 && read_checks >= 2 * `LT_BUF_DEPTH) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- line_tracker.f
+incdir+verilog
verilog/line_tracker_pkg.sv
verilog/sample_buffer_ram.sv
verilog/sample_controller.sv
verilog/buffer_port_arbiter.sv
verilog/line_tracker_top.sv
bench/line_tracker_checker.sv
bench/line_tracker_tb.sv

//--- verilog/buffer_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// picks sampler or host access to the shared buffer port
// the sampler keeps the port one extra cycle after stall so its last write lands
module buffer_port_arbiter (
	input  logic clock_i,
	input  logic resetn_i,
	input  line_tracker_pkg::tracker_ctrl_t ctrl_i,
	input  logic stall_i,
	input  line_tracker_pkg::buf_port_t sampler_port_i,
	output line_tracker_pkg::buf_port_t ram_port_o
);

	line_tracker_pkg::access_state_t state_q;
	line_tracker_pkg::access_state_t state_next;
	line_tracker_pkg::buf_port_t port_next;

	// ------------------------------
	// next owner
	// ------------------------------
	always_comb begin
		state_next = state_q;
		if (!ctrl_i.track_en) begin
			// host may read whenever tracking is off
			state_next = line_tracker_pkg::HOST;
		end else begin
			case (state_q)
				line_tracker_pkg::SAMPLER: begin
					// stall just rose, hold the sampler for one more cycle
					if (stall_i) begin
						state_next = line_tracker_pkg::HANDOVER;
					end
				end
				line_tracker_pkg::HANDOVER: begin
					state_next = stall_i ? line_tracker_pkg::HOST : line_tracker_pkg::SAMPLER;
				end
				default: begin
					// clear drops stall and gives the port back
					state_next = stall_i ? line_tracker_pkg::HOST : line_tracker_pkg::SAMPLER;
				end
			endcase
		end

		// host reads only, never writes
		if (state_next == line_tracker_pkg::HOST) begin
			port_next = '{wr_en: 1'b0, addr: ctrl_i.rd_addr};
		end else begin
			port_next = sampler_port_i;
		end
	end

	// ------------------------------
	// registered port
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= line_tracker_pkg::SAMPLER;
			ram_port_o <= '0;
		end else begin
			state_q <= state_next;
			ram_port_o <= port_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/line_tracker_defines.svh
`ifndef LINE_TRACKER_DEFINES_SVH
`define LINE_TRACKER_DEFINES_SVH

// ------------------------------
// tracker geometry
// ------------------------------

// cache lines tracked per policy vector
`define LT_N_LINES 16

// sample buffer entries and the address width that covers them
`define LT_BUF_DEPTH 32
`define LT_ADDR_W 5

// request counter width and counted requests per stored sample
`define LT_TRACE_W 32
`define LT_SAMPLE_PERIOD 3

`endif

//--- verilog/line_tracker_pkg.sv
`default_nettype none

`include "line_tracker_defines.svh"

package line_tracker_pkg;

	// ------------------------------
	// plain vector widths
	// ------------------------------
	typedef logic [`LT_N_LINES-1:0] line_mask_t;
	typedef logic [`LT_ADDR_W-1:0] buf_addr_t;
	// one extra bit so a full buffer can be counted
	typedef logic [`LT_ADDR_W:0] buf_count_t;
	typedef logic [`LT_TRACE_W-1:0] trace_t;

	// ------------------------------
	// grouped signals
	// ------------------------------

	// expiry vectors of one access, one per replacement policy
	typedef struct packed {
		line_mask_t policy0;
		line_mask_t policy1;
		line_mask_t policy2;
	} expiry_set_t;

	// host control word
	typedef struct packed {
		logic track_en;
		logic clear;
		buf_addr_t rd_addr;
	} tracker_ctrl_t;

	// one access to the buffer port
	typedef struct packed {
		logic wr_en;
		buf_addr_t addr;
	} buf_port_t;

	// who owns the buffer port
	typedef enum logic [1:0] {
		SAMPLER,
		HANDOVER,
		HOST
	} access_state_t;

endpackage

`default_nettype wire

//--- verilog/line_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_tracker_defines.svh"

// cache line expiry tracker
// samples expiry vectors into a buffer for host readout
module line_tracker_top (
	input  logic clock_i,
	input  logic resetn_i,
	input  line_tracker_pkg::tracker_ctrl_t ctrl_i,
	input  logic request_i,
	input  logic en_i,
	input  line_tracker_pkg::expiry_set_t expiry_i,
	output logic stall_o,
	output line_tracker_pkg::buf_count_t count_o,
	output line_tracker_pkg::expiry_set_t expiry_o,
	output line_tracker_pkg::trace_t trace_o
);

	// ------------------------------
	// internal nets
	// ------------------------------

	// sampler side of the buffer
	line_tracker_pkg::buf_port_t sampler_port;
	line_tracker_pkg::expiry_set_t wr_expiry;
	line_tracker_pkg::trace_t wr_trace;
	logic stall;

	// arbitrated port shared by both RAMs
	line_tracker_pkg::buf_port_t ram_port;

	// sampling and stall control
	sample_controller u_controller (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.ctrl_i         (ctrl_i),
		.request_i      (request_i),
		.en_i           (en_i),
		.expiry_i       (expiry_i),
		.stall_o        (stall),
		.count_o        (count_o),
		.sampler_port_o (sampler_port),
		.wr_expiry_o    (wr_expiry),
		.wr_trace_o     (wr_trace)
	);

	// buffer port ownership
	buffer_port_arbiter u_arbiter (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.ctrl_i         (ctrl_i),
		.stall_i        (stall),
		.sampler_port_i (sampler_port),
		.ram_port_o     (ram_port)
	);

	// ------------------------------
	// buffer halves
	// ------------------------------

	// three expiry vectors per record
	sample_buffer_ram #(
		.WIDTH ($bits(line_tracker_pkg::expiry_set_t)),
		.DEPTH (`LT_BUF_DEPTH)
	) u_expiry_ram (
		.clock_i (clock_i),
		.wr_en_i (ram_port.wr_en),
		.addr_i  (ram_port.addr),
		.data_i  (wr_expiry),
		.data_o  (expiry_o)
	);

	// request count per record
	sample_buffer_ram #(
		.WIDTH ($bits(line_tracker_pkg::trace_t)),
		.DEPTH (`LT_BUF_DEPTH)
	) u_trace_ram (
		.clock_i (clock_i),
		.wr_en_i (ram_port.wr_en),
		.addr_i  (ram_port.addr),
		.data_i  (wr_trace),
		.data_o  (trace_o)
	);

	assign stall_o = stall;

endmodule

`default_nettype wire

//--- verilog/sample_buffer_ram.sv
`timescale 1ns/1ps
`default_nettype none

// single port buffer RAM
// one port serves both the sampler writes and the host reads
module sample_buffer_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 32
) (
	input  logic clock_i,
	input  logic wr_en_i,
	input  line_tracker_pkg::buf_addr_t addr_i,
	input  logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o
);

	// storage array
	logic [WIDTH-1:0] mem_q [DEPTH];

	// ------------------------------
	// write port
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (wr_en_i) begin
			mem_q[addr_i] <= data_i;
		end
	end

	// ------------------------------
	// read port
	// ------------------------------

	// addressed entry registered every cycle
	// a write in the same cycle returns the old contents
	always_ff @(posedge clock_i) begin
		data_o <= mem_q[addr_i];
	end

endmodule

`default_nettype wire

//--- verilog/sample_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_tracker_defines.svh"

// request counting and sample generation
// stalls the cache controller once the buffer is full
module sample_controller (
	input  logic clock_i,
	input  logic resetn_i,
	input  line_tracker_pkg::tracker_ctrl_t ctrl_i,
	input  logic request_i,
	input  logic en_i,
	input  line_tracker_pkg::expiry_set_t expiry_i,
	output logic stall_o,
	output line_tracker_pkg::buf_count_t count_o,
	output line_tracker_pkg::buf_port_t sampler_port_o,
	output line_tracker_pkg::expiry_set_t wr_expiry_o,
	output line_tracker_pkg::trace_t wr_trace_o
);

	// period counter must hold the reload value
	localparam int PERIOD_W = $clog2(`LT_SAMPLE_PERIOD + 1);

	// ------------------------------
	// state
	// ------------------------------

	// counted requests left until the next sample
	logic [PERIOD_W-1:0] period_q;
	// running count of counted requests
	line_tracker_pkg::trace_t trace_q;
	// records stored so far, also the next write address
	line_tracker_pkg::buf_count_t count_q;
	logic stall_q;

	// write pulse and the record it carries
	logic wr_en_q;
	line_tracker_pkg::buf_addr_t wr_addr_q;
	line_tracker_pkg::expiry_set_t wr_expiry_q;
	line_tracker_pkg::trace_t wr_trace_q;

	// ------------------------------
	// sampling decision
	// ------------------------------
	logic counted;
	logic sample;
	line_tracker_pkg::buf_count_t count_base;
	line_tracker_pkg::buf_count_t count_inc;

	always_comb begin
		// requests only count while tracking, enabled and not stalled
		counted = ctrl_i.track_en & ~stall_q & en_i & request_i;
		// this request brings the period counter to zero
		sample = counted && (period_q == PERIOD_W'(1));
		// clear restarts the buffer at address 0
		count_base = ctrl_i.clear ? '0 : count_q;
		count_inc = count_base + 1'b1;
	end

	// ------------------------------
	// control registers
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			period_q <= PERIOD_W'(`LT_SAMPLE_PERIOD);
			trace_q <= '0;
			count_q <= '0;
			stall_q <= 1'b0;
			wr_en_q <= 1'b0;
		end else begin
			// write pulse lasts exactly one cycle
			wr_en_q <= sample;

			// trace and period counters survive a clear
			if (counted) begin
				trace_q <= trace_q + 1'b1;
				if (sample) begin
					period_q <= PERIOD_W'(`LT_SAMPLE_PERIOD);
				end else begin
					period_q <= period_q - 1'b1;
				end
			end

			// new record bumps the count
			// stall rises on the edge the last entry is taken
			if (sample) begin
				count_q <= count_inc;
				stall_q <= (count_inc == line_tracker_pkg::buf_count_t'(`LT_BUF_DEPTH));
			end else if (ctrl_i.clear) begin
				count_q <= '0;
				stall_q <= 1'b0;
			end
		end
	end

	// ------------------------------
	// record latch
	// ------------------------------

	// trace holds the requests counted before the sampled one
	always_ff @(posedge clock_i) begin
		if (sample) begin
			wr_addr_q <= line_tracker_pkg::buf_addr_t'(count_base);
			wr_expiry_q <= expiry_i;
			wr_trace_q <= trace_q;
		end
	end

	// outputs
	assign stall_o = stall_q;
	assign count_o = count_q;
	assign sampler_port_o = '{wr_en: wr_en_q, addr: wr_addr_q};
	assign wr_expiry_o = wr_expiry_q;
	assign wr_trace_o = wr_trace_q;

endmodule

`default_nettype wire
